// File: project.f
+incdir+include
logic/udp_pkg.sv
logic/csum_pkg.sv
logic/beat_sum.sv
logic/udp_csum_engine.sv
logic/hdr_fifo.sv
logic/payload_fifo.sv
logic/udp_csum_top.sv
tb/tb_udp_csum.sv

// File: run_sim.sh
#!/bin/sh
# compile the UDP checksum design and testbench with Verilator, then run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f \
    --top-module tb_udp_csum -Mdir obj_dir -o tb_udp_csum
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/tb_udp_csum
status=$?
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit $status
fi

exit 0

// File: include/tb_csum_model.svh
// reference functions for payload bytes, UDP length and UDP checksum
`ifndef TB_CSUM_MODEL_SVH
`define TB_CSUM_MODEL_SVH

// byte k of a frame built from its seed
function automatic logic [7:0] model_byte(input logic [7:0] seed, input int k);
    return (seed ^ 8'(k * 7)) + 8'(k >> 3);
endfunction

// UDP length covers the 8-byte header
function automatic udp_pkg::len_t model_len(input int payload_len);
    return udp_pkg::len_t'(payload_len + udp_pkg::UDP_HDR_BYTES);
endfunction

function automatic udp_pkg::csum_t model_csum(input udp_pkg::udp_hdr_t hdr,
                                              input logic [7:0] seed,
                                              input int payload_len);
    logic [31:0]   sum;
    logic [15:0]   word;
    udp_pkg::len_t len;

    len = model_len(payload_len);
    // pseudo-header, then the UDP header with a zero checksum field
    sum = 32'(hdr.src_ip[31:16]) + 32'(hdr.src_ip[15:0]);
    sum = sum + 32'(hdr.dst_ip[31:16]) + 32'(hdr.dst_ip[15:0]);
    sum = sum + 32'(udp_pkg::IP_PROTO_UDP) + 32'(len) + 32'(len);
    sum = sum + 32'(hdr.src_port) + 32'(hdr.dst_port);
    // payload words, odd tail padded with zero
    for (int k = 0; k < payload_len; k += 2) begin
        if (k + 1 < payload_len) begin
            word = {model_byte(seed, k), model_byte(seed, k + 1)};
        end else begin
            word = {model_byte(seed, k), 8'h00};
        end
        sum = sum + 32'(word);
    end
    while (sum[31:16] != 16'h0000) begin
        sum = 32'(sum[15:0]) + 32'(sum[31:16]);
    end
    return ~sum[15:0];
endfunction

`endif

// File: tb/tb_udp_csum.sv
// testbench for udp_csum_top with frame table, driver, collector, checks and watchdog
`timescale 1ns/1ps

module tb_udp_csum;

    typedef struct packed {
        udp_pkg::udp_hdr_t hdr;
        logic [7:0]        plen;
        logic              user;
        logic [7:0]        seed;
    } frame_t;

    localparam int NUM_FRAMES = 10;

    // header, payload bytes, user bit, byte seed
    localparam frame_t FRAMES [NUM_FRAMES] = '{
        '{'{32'hc0a8_0001, 32'hc0a8_0002, 16'd4000, 16'd53}, 8'd1, 1'b0, 8'h3c},
        '{'{32'h0a00_0001, 32'h0a00_00fe, 16'h1234, 16'h5678}, 8'd8, 1'b0, 8'ha5},
        '{'{32'hffff_ffff, 32'hffff_ffff, 16'hffff, 16'hffff}, 8'd13, 1'b1, 8'hff},
        '{'{32'h7f00_0001, 32'h7f00_0001, 16'd0, 16'd0}, 8'd16, 1'b0, 8'h00},
        '{'{32'hac10_0a05, 32'h0808_0808, 16'd50000, 16'd443}, 8'd70, 1'b1, 8'h91},
        '{'{32'hc000_0201, 32'hc633_6402, 16'd68, 16'd67}, 8'd2, 1'b0, 8'h7e},
        '{'{32'h0102_0304, 32'h0506_0708, 16'd9, 16'd9}, 8'd64, 1'b0, 8'h12},
        '{'{32'hdead_beef, 32'hcafe_f00d, 16'h1111, 16'h2222}, 8'd31, 1'b1, 8'hc8},
        '{'{32'h0000_0000, 32'h0000_0000, 16'd1, 16'd2}, 8'd7, 1'b0, 8'h44},
        '{'{32'h8c52_0d1e, 32'h1f2e_3d4c, 16'd33333, 16'd161}, 8'd9, 1'b0, 8'he3}
    };

    logic              clk;
    logic              rst;
    udp_pkg::udp_hdr_t s_hdr;
    logic              s_hdr_valid;
    logic              s_hdr_ready;
    udp_pkg::beat_t    s_beat;
    logic              s_beat_valid;
    logic              s_beat_ready;
    udp_pkg::udp_res_t m_res;
    logic              m_res_valid;
    logic              m_res_ready;
    udp_pkg::beat_t    m_beat;
    logic              m_beat_valid;
    logic              m_beat_ready;
    logic              busy;

    // ready pattern controls
    logic              rand_ready = 1'b0;
    logic              res_hold = 1'b0;

    udp_pkg::udp_res_t exp_res [$];
    udp_pkg::beat_t    exp_beats [$];
    int                hdr_accepted = 0;
    int                res_count = 0;
    int                beat_count = 0;
    string             test_name;

    `include "tb_csum_model.svh"

    udp_csum_top udp_csum_top_i (.*);

    task automatic check_value(input string what, input logic [127:0] expected,
                               input logic [127:0] actual);
        assert (actual === expected) else begin
            $display("** Error: test %s, %s: expected %h, actual %h",
                     test_name, what, expected, actual);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    function automatic int frame_beats(input frame_t f);
        return (int'(f.plen) + udp_pkg::DATA_BYTES - 1) / udp_pkg::DATA_BYTES;
    endfunction

    // beat b of a frame, keep full except on the tail
    function automatic udp_pkg::beat_t make_beat(input frame_t f, input int b);
        udp_pkg::beat_t beat;
        int             k;

        beat = '0;
        for (int i = 0; i < udp_pkg::DATA_BYTES; i++) begin
            k = b * udp_pkg::DATA_BYTES + i;
            if (k < int'(f.plen)) begin
                beat.data[i*8 +: 8] = model_byte(f.seed, k);
                beat.keep[i]        = 1'b1;
            end
        end
        beat.last = (b == frame_beats(f) - 1);
        beat.user = beat.last && f.user;
        return beat;
    endfunction

    task automatic send_frame(input frame_t f);
        udp_pkg::udp_res_t expected;

        expected.hdr  = f.hdr;
        expected.len  = model_len(int'(f.plen));
        expected.csum = model_csum(f.hdr, f.seed, int'(f.plen));
        exp_res.push_back(expected);
        s_hdr       <= f.hdr;
        s_hdr_valid <= 1'b1;
        do begin
            @(posedge clk);
        end while (!s_hdr_ready);
        s_hdr_valid <= 1'b0;
        hdr_accepted++;
        for (int b = 0; b < frame_beats(f); b++) begin
            exp_beats.push_back(make_beat(f, b));
            s_beat       <= make_beat(f, b);
            s_beat_valid <= 1'b1;
            // the frame is being summed until its last beat is taken
            do begin
                @(posedge clk);
                check_value("busy while summing", 128'(1), 128'(busy));
            end while (!s_beat_ready);
        end
        s_beat_valid <= 1'b0;
    endtask

    task automatic send_frames();
        for (int i = 0; i < NUM_FRAMES; i++) begin
            send_frame(FRAMES[i]);
        end
    endtask

    // wait for every expected item, then the DUT should sit idle
    task automatic drain();
        while (exp_res.size() != 0 || exp_beats.size() != 0) begin
            @(posedge clk);
        end
        @(posedge clk);
        check_value("busy and output valids when drained", '0,
                    128'({busy, m_res_valid, m_beat_valid}));
    endtask

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    initial begin
        void'($urandom(72));
        m_res_ready  = 1'b0;
        m_beat_ready = 1'b0;
        forever begin
            @(posedge clk);
            m_res_ready  <= rand_ready ? 1'($urandom()) : !res_hold;
            m_beat_ready <= rand_ready ? 1'($urandom()) : 1'b1;
        end
    end

    // collector for results and payload beats
    initial begin
        forever begin
            @(posedge clk);
            if (m_res_valid && m_res_ready) begin
                assert (exp_res.size() != 0) else begin
                    $display("a result left the DUT with no frame outstanding");
                    $display("TB FAILED");
                    $fatal(1);
                end
                check_value($sformatf("result %0d", res_count), 128'(exp_res.pop_front()),
                            128'(m_res));
                res_count++;
            end
            if (m_beat_valid && m_beat_ready) begin
                assert (exp_beats.size() != 0) else begin
                    $display("a payload beat left the DUT with no beat outstanding");
                    $display("TB FAILED");
                    $fatal(1);
                end
                check_value($sformatf("beat %0d", beat_count), 128'(exp_beats.pop_front()),
                            128'(m_beat));
                beat_count++;
            end
        end
    end

    // three passes over the table
    initial begin
        int limit;

        limit = 0;
        for (int i = 0; i < NUM_FRAMES; i++) begin
            limit += 3 * 40 * frame_beats(FRAMES[i]);
        end
        limit += 1000;
        repeat (limit) @(posedge clk);
        $display("watchdog expired after %0d cycles, the run did not complete", limit);
        $display("TB FAILED");
        $fatal(1);
    end

    initial begin
        int base;

        rst          = 1'b1;
        s_hdr        = '0;
        s_hdr_valid  = 1'b0;
        s_beat       = '0;
        s_beat_valid = 1'b0;
        test_name    = "reset";
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("outputs after reset", '0,
                    128'({s_hdr_ready, s_beat_ready, m_res_valid, m_beat_valid, busy}));
        @(posedge clk);
        check_value("s_hdr_ready in idle", 128'(1), 128'(s_hdr_ready));

        test_name = "full ready";
        send_frames();
        drain();

        test_name  = "random ready";
        rand_ready <= 1'b1;
        send_frames();
        drain();

        // result side blocked, header FIFO should take exactly 8
        test_name  = "held result ready";
        rand_ready <= 1'b0;
        res_hold   <= 1'b1;
        base = hdr_accepted;
        fork
            send_frames();
        join_none
        while (hdr_accepted - base < 8) begin
            @(posedge clk);
        end
        repeat (60) begin
            @(posedge clk);
            check_value("s_hdr_ready while results blocked", '0, 128'(s_hdr_ready));
        end
        res_hold <= 1'b0;
        while (hdr_accepted - base < NUM_FRAMES) begin
            @(posedge clk);
        end
        drain();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: logic/udp_csum_top.sv
// top level with the summing engine, the header FIFO and the payload FIFO
`timescale 1ns/1ps

module udp_csum_top (
    input  logic               clk,
    input  logic               rst,

    // header and payload in
    input  udp_pkg::udp_hdr_t  s_hdr,
    input  logic               s_hdr_valid,
    output logic               s_hdr_ready,
    input  udp_pkg::beat_t     s_beat,
    input  logic               s_beat_valid,
    output logic               s_beat_ready,

    // finished header and payload out
    output udp_pkg::udp_res_t  m_res,
    output logic               m_res_valid,
    input  logic               m_res_ready,
    output udp_pkg::beat_t     m_beat,
    output logic               m_beat_valid,
    input  logic               m_beat_ready,

    output logic               busy
);

    logic              fifo_valid;
    logic              fifo_ready;
    udp_pkg::udp_res_t res;
    logic              res_valid;
    logic              res_room;

    udp_csum_engine udp_csum_engine_i (
        .clk          (clk),
        .rst          (rst),
        .s_hdr        (s_hdr),
        .s_hdr_valid  (s_hdr_valid),
        .s_hdr_ready  (s_hdr_ready),
        .s_beat       (s_beat),
        .s_beat_valid (s_beat_valid),
        .s_beat_ready (s_beat_ready),
        .fifo_valid   (fifo_valid),
        .fifo_ready   (fifo_ready),
        .res          (res),
        .res_valid    (res_valid),
        .res_room     (res_room),
        .busy         (busy)
    );

    hdr_fifo hdr_fifo_i (
        .clk         (clk),
        .rst         (rst),
        .wr          (res),
        .wr_valid    (res_valid),
        .wr_room     (res_room),
        .m_res       (m_res),
        .m_res_valid (m_res_valid),
        .m_res_ready (m_res_ready)
    );

    // beat data goes straight in, the engine only gates the handshake
    payload_fifo payload_fifo_i (
        .clk     (clk),
        .rst     (rst),
        .s       (s_beat),
        .s_valid (fifo_valid),
        .s_ready (fifo_ready),
        .m       (m_beat),
        .m_valid (m_beat_valid),
        .m_ready (m_beat_ready)
    );

endmodule

// File: logic/payload_fifo.sv
// payload beat queue with a direct memory read at the output
`timescale 1ns/1ps

module payload_fifo (
    input  logic            clk,
    input  logic            rst,
    input  udp_pkg::beat_t  s,
    input  logic            s_valid,
    output logic            s_ready,
    output udp_pkg::beat_t  m,
    output logic            m_valid,
    input  logic            m_ready
);

    udp_pkg::beat_t mem [2**csum_pkg::PAYLOAD_FIFO_AW];

    logic [csum_pkg::PAYLOAD_FIFO_AW:0] wr_ptr;
    logic [csum_pkg::PAYLOAD_FIFO_AW:0] rd_ptr;
    logic                               full;
    logic                               empty;
    logic                               do_write;
    logic                               do_read;

    // wrap bits differ with equal addresses when full
    assign full  = (wr_ptr[csum_pkg::PAYLOAD_FIFO_AW] != rd_ptr[csum_pkg::PAYLOAD_FIFO_AW]) &&
                   (wr_ptr[csum_pkg::PAYLOAD_FIFO_AW-1:0] ==
                    rd_ptr[csum_pkg::PAYLOAD_FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);

    assign s_ready = !full;
    assign m_valid = !empty;

    // head beat shows the cycle after its write
    assign m = mem[rd_ptr[csum_pkg::PAYLOAD_FIFO_AW-1:0]];

    assign do_write = s_valid && s_ready;
    assign do_read  = m_valid && m_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (do_read) begin
                rd_ptr <= rd_ptr + 1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[csum_pkg::PAYLOAD_FIFO_AW-1:0]] <= s;
        end
    end

endmodule

// File: logic/hdr_fifo.sv
// result queue of finished headers with a registered output stage
`timescale 1ns/1ps

module hdr_fifo (
    input  logic               clk,
    input  logic               rst,
    input  udp_pkg::udp_res_t  wr,
    input  logic               wr_valid,
    output logic               wr_room,
    output udp_pkg::udp_res_t  m_res,
    output logic               m_res_valid,
    input  logic               m_res_ready
);

    udp_pkg::udp_res_t mem [2**csum_pkg::HDR_FIFO_AW];

    logic [csum_pkg::HDR_FIFO_AW:0]   wr_ptr;
    logic [csum_pkg::HDR_FIFO_AW:0]   rd_ptr;
    logic [csum_pkg::HDR_FIFO_AW:0]   used;
    logic [csum_pkg::HDR_FIFO_AW+1:0] fill;
    logic                             full;
    logic                             empty;
    logic                             do_write;
    logic                             do_read;

    // pointers one bit wider than the address
    assign full  = (wr_ptr[csum_pkg::HDR_FIFO_AW] != rd_ptr[csum_pkg::HDR_FIFO_AW]) &&
                   (wr_ptr[csum_pkg::HDR_FIFO_AW-1:0] == rd_ptr[csum_pkg::HDR_FIFO_AW-1:0]);
    assign empty = (wr_ptr == rd_ptr);
    assign used  = wr_ptr - rd_ptr;

    // occupancy counts the output register and a write in flight
    assign fill    = (csum_pkg::HDR_FIFO_AW + 2)'(used) +
                     (csum_pkg::HDR_FIFO_AW + 2)'(m_res_valid) +
                     (csum_pkg::HDR_FIFO_AW + 2)'(wr_valid);
    assign wr_room = (fill[csum_pkg::HDR_FIFO_AW+1:csum_pkg::HDR_FIFO_AW] == 2'b00);

    assign do_write = wr_valid && !full;
    assign do_read  = !empty && (m_res_ready || !m_res_valid);

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr      <= '0;
            rd_ptr      <= '0;
            m_res_valid <= 1'b0;
        end else begin
            if (do_write) begin
                wr_ptr <= wr_ptr + 1;
            end
            if (do_read) begin
                rd_ptr      <= rd_ptr + 1;
                m_res_valid <= 1'b1;
            end else if (m_res_ready) begin
                m_res_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_write) begin
            mem[wr_ptr[csum_pkg::HDR_FIFO_AW-1:0]] <= wr;
        end
        if (do_read) begin
            m_res <= mem[rd_ptr[csum_pkg::HDR_FIFO_AW-1:0]];
        end
    end

endmodule

// File: logic/udp_csum_engine.sv
// summing FSM that captures the header, gates the payload and folds the checksum
`timescale 1ns/1ps

module udp_csum_engine (
    input  logic               clk,
    input  logic               rst,
    input  udp_pkg::udp_hdr_t  s_hdr,
    input  logic               s_hdr_valid,
    output logic               s_hdr_ready,
    input  udp_pkg::beat_t     s_beat,
    input  logic               s_beat_valid,
    output logic               s_beat_ready,
    output logic               fifo_valid,
    input  logic               fifo_ready,
    output udp_pkg::udp_res_t  res,
    output logic               res_valid,
    input  logic               res_room,
    output logic               busy
);

    csum_pkg::sum_state_t state, state_next;
    logic                 hdr_ready_next;
    logic                 store_hdr;
    logic                 shift_in;
    logic                 beat_fire;

    udp_pkg::udp_hdr_t    hdr_q;
    csum_pkg::acc_t       acc, acc_next;
    csum_pkg::part_t      part_a, part_a_next;
    csum_pkg::part_t      part_b, part_b_next;
    udp_pkg::len_t        len_q, len_next;
    udp_pkg::csum_t       csum_q;
    csum_pkg::part_t      fold;

    logic [3:0]           beat_cnt;
    csum_pkg::part_t      beat_lo;
    csum_pkg::part_t      beat_hi;

    beat_sum beat_sum_i (
        .beat     (s_beat),
        .byte_cnt (beat_cnt),
        .part_lo  (beat_lo),
        .part_hi  (beat_hi)
    );

    // payload only moves while summing it
    assign shift_in     = (state == csum_pkg::ST_SUM_PAYLOAD);
    assign fifo_valid   = s_beat_valid && shift_in;
    assign s_beat_ready = fifo_ready && shift_in;
    assign beat_fire    = s_beat_valid && s_beat_ready;

    // first fold of the high half
    assign fold = csum_pkg::part_t'(acc[15:0]) + csum_pkg::part_t'(acc[31:16]);

    assign res = udp_pkg::udp_res_t'{hdr: hdr_q, len: len_q, csum: csum_q};

    always_comb begin
        state_next     = state;
        hdr_ready_next = 1'b0;
        store_hdr      = 1'b0;
        acc_next       = acc;
        part_a_next    = part_a;
        part_b_next    = part_b;
        len_next       = len_q;

        case (state)
            csum_pkg::ST_IDLE: begin
                hdr_ready_next = res_room;
                if (s_hdr_ready && s_hdr_valid) begin
                    store_hdr      = 1'b1;
                    hdr_ready_next = 1'b0;
                    acc_next       = csum_pkg::SUM_INIT;
                    part_a_next    = csum_pkg::part_t'(s_hdr.src_ip[31:16]);
                    part_b_next    = csum_pkg::part_t'(s_hdr.src_ip[15:0]);
                    len_next       = udp_pkg::len_t'(udp_pkg::UDP_HDR_BYTES);
                    state_next     = csum_pkg::ST_SUM_HEADER;
                end
            end
            csum_pkg::ST_SUM_HEADER: begin
                acc_next    = acc + csum_pkg::acc_t'(part_a) + csum_pkg::acc_t'(part_b);
                part_a_next = csum_pkg::part_t'(hdr_q.dst_ip[31:16]) +
                              csum_pkg::part_t'(hdr_q.dst_ip[15:0]);
                part_b_next = csum_pkg::part_t'(hdr_q.src_port) +
                              csum_pkg::part_t'(hdr_q.dst_port);
                state_next  = csum_pkg::ST_SUM_PAYLOAD;
            end
            csum_pkg::ST_SUM_PAYLOAD: begin
                if (beat_fire) begin
                    // previous partials plus the byte count for both length copies
                    acc_next    = acc + csum_pkg::acc_t'(part_a) + csum_pkg::acc_t'(part_b) +
                                  csum_pkg::acc_t'({beat_cnt, 1'b0});
                    part_a_next = beat_lo;
                    part_b_next = beat_hi;
                    len_next    = len_q + udp_pkg::len_t'(beat_cnt);
                    if (s_beat.last) begin
                        state_next = csum_pkg::ST_FINISH_1;
                    end
                end
            end
            csum_pkg::ST_FINISH_1: begin
                // drain the last partials
                acc_next   = acc + csum_pkg::acc_t'(part_a) + csum_pkg::acc_t'(part_b);
                state_next = csum_pkg::ST_FINISH_2;
            end
            csum_pkg::ST_FINISH_2: begin
                state_next = csum_pkg::ST_IDLE;
            end
            default: begin
                state_next = csum_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state       <= csum_pkg::ST_IDLE;
            s_hdr_ready <= 1'b0;
            res_valid   <= 1'b0;
            busy        <= 1'b0;
        end else begin
            state       <= state_next;
            s_hdr_ready <= hdr_ready_next;
            res_valid   <= (state == csum_pkg::ST_FINISH_2);
            busy        <= (state_next != csum_pkg::ST_IDLE);
        end
    end

    always_ff @(posedge clk) begin
        acc    <= acc_next;
        part_a <= part_a_next;
        part_b <= part_b_next;
        len_q  <= len_next;
        if (store_hdr) begin
            hdr_q <= s_hdr;
        end
        // second fold absorbs the carry, then invert
        if (state == csum_pkg::ST_FINISH_2) begin
            csum_q <= ~(fold[15:0] + udp_pkg::csum_t'(fold[16]));
        end
    end

endmodule

// File: logic/beat_sum.sv
// byte count and two big-endian partial sums of one payload beat
`timescale 1ns/1ps

module beat_sum (
    input  udp_pkg::beat_t   beat,
    output logic [3:0]       byte_cnt,
    output csum_pkg::part_t  part_lo,
    output csum_pkg::part_t  part_hi
);

    // keep is contiguous from bit 0, so the top set bit gives the count
    always_comb begin
        byte_cnt = 4'd0;
        for (int i = 0; i < udp_pkg::DATA_BYTES; i++) begin
            if (beat.keep[i]) begin
                byte_cnt = 4'(i + 1);
            end
        end
    end

    // bytes 0..3 into part_lo, bytes 4..7 into part_hi
    always_comb begin
        logic [7:0]  octet;
        logic [15:0] word;

        part_lo = '0;
        part_hi = '0;
        for (int i = 0; i < udp_pkg::DATA_BYTES; i++) begin
            octet = beat.keep[i] ? beat.data[i*8 +: 8] : 8'h00;
            // even index is the high octet of a word
            if (i % 2 == 0) begin
                word = {octet, 8'h00};
            end else begin
                word = {8'h00, octet};
            end
            if (i < udp_pkg::DATA_BYTES / 2) begin
                part_lo = part_lo + csum_pkg::part_t'(word);
            end else begin
                part_hi = part_hi + csum_pkg::part_t'(word);
            end
        end
    end

endmodule

// File: logic/csum_pkg.sv
// checksum widths, starting sum, FIFO address widths and the summing state enum
package csum_pkg;

    // running ones-complement sum before folding
    typedef logic [31:0] acc_t;

    // 16-bit partial sum plus its carry
    typedef logic [16:0] part_t;

    localparam int HDR_FIFO_AW = 3;
    localparam int PAYLOAD_FIFO_AW = 8;

    // pseudo-header protocol word plus both copies of the UDP header length
    localparam acc_t SUM_INIT = acc_t'(udp_pkg::IP_PROTO_UDP) +
                                acc_t'(2 * udp_pkg::UDP_HDR_BYTES);

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_SUM_HEADER,
        ST_SUM_PAYLOAD,
        ST_FINISH_1,
        ST_FINISH_2
    } sum_state_t;

endpackage

// File: logic/udp_pkg.sv
// UDP frame field types, header and result structs, payload beat struct, frame constants
package udp_pkg;

    // bytes per payload beat on the 64-bit datapath
    localparam int DATA_BYTES = 8;

    // fixed UDP header size in bytes
    localparam int UDP_HDR_BYTES = 8;

    // IPv4 protocol number for UDP
    localparam logic [7:0] IP_PROTO_UDP = 8'h11;

    typedef logic [31:0] ip_addr_t;
    typedef logic [15:0] port_t;

    // UDP length, header included
    typedef logic [15:0] len_t;

    typedef logic [15:0] csum_t;

    // parallel header as it arrives with a frame
    typedef struct packed {
        ip_addr_t src_ip;
        ip_addr_t dst_ip;
        port_t    src_port;
        port_t    dst_port;
    } udp_hdr_t;

    // header with the computed length and checksum
    typedef struct packed {
        udp_hdr_t hdr;
        len_t     len;
        csum_t    csum;
    } udp_res_t;

    // one payload beat, byte 0 in data[7:0]
    typedef struct packed {
        logic [8*DATA_BYTES-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
        logic                    user;
    } beat_t;

endpackage
